//--- include/fdtd_cfg.svh
/*
 FDTD tile engine configuration
 Tile size, field precision and pipeline latencies
*/
`ifndef FDTD_CFG_SVH
`define FDTD_CFG_SVH

// Tile geometry
`define FDTD_W 3 // Core cells across
`define FDTD_H 3 // Core cells down

// Precision
`define FDTD_FBITS 18     // Bits per field
`define FDTD_ABITS 8      // Region memory address
`define FDTD_COEF_FRAC 16 // Coefficient fraction bits

// Latencies seen at the ports
`define FDTD_STEP_LAT 13 // Read address to matching write strobe
`define FDTD_LD_LAT 3    // Load strobe to snapshot on o_dout

`endif

//--- src/fdtd_pkg.sv
/*
 FDTD tile engine types
 Field, cell, halo grid, coefficient and address types
*/
`include "fdtd_cfg.svh"

package fdtd_pkg;

	typedef logic signed [`FDTD_FBITS-1:0] field_t;

	// One cell as the pipeline sees it
	typedef struct packed {
		field_t ex;
		field_t ey;
		field_t hzx;
		field_t hzy;
	} cell_fields_t;

	// Same word as raw bits for memories and serial load
	typedef union packed {
		cell_fields_t f;
		logic [4*`FDTD_FBITS-1:0] bits;
	} cell_u;

	typedef cell_u [`FDTD_H-1:0][`FDTD_W-1:0] core_tile_t;        // Slot y*W+x
	typedef field_t [`FDTD_H+1:0][`FDTD_W+1:0] halo_grid_t;       // Core plus one cell ring
	typedef field_t [7:0] coef_vec_t;                             // c0 to c7
	typedef logic [`FDTD_ABITS-1:0] addr_t;
	typedef addr_t [2:0][2:0] region_addr_t;                      // [row][col]

endpackage

//--- src/tile_ram.sv
/*
 Tile region memory
 Simple dual port, registered read address and read data
*/
`include "fdtd_cfg.svh"

module tile_ram #(
	parameter int DATA_BITS = 72
) (
	input logic clk,
	input logic i_we,
	input fdtd_pkg::addr_t i_waddr,
	input fdtd_pkg::addr_t i_raddr,
	input logic [DATA_BITS-1:0] i_wdata,
	output logic [DATA_BITS-1:0] o_rdata
);
	import fdtd_pkg::*;

	logic [DATA_BITS-1:0] mem [2**`FDTD_ABITS];
	addr_t raddr_q;

	always_ff @(posedge clk) begin
		if (i_we) mem[i_waddr] <= i_wdata;
		raddr_q <= i_raddr;
		o_rdata <= mem[raddr_q]; // Old data on same-address write
	end
endmodule

//--- src/coef_mult.sv
/*
 Coefficient multiplier
 Signed field times coefficient, registered in and out, rescaled
*/
`include "fdtd_cfg.svh"

module coef_mult (
	input logic clk,
	input fdtd_pkg::field_t i_a,
	input fdtd_pkg::field_t i_c,
	output fdtd_pkg::field_t o_p
);
	import fdtd_pkg::*;

	field_t a_q;
	field_t c_q;
	logic signed [2*`FDTD_FBITS-1:0] prod;

	assign prod = a_q * c_q; // Full precision

	always_ff @(posedge clk) begin
		a_q <= i_a;
		c_q <= i_c;
		o_p <= prod[`FDTD_COEF_FRAC +: `FDTD_FBITS]; // Drop fraction, high bits wrap
	end
endmodule

//--- src/tile_store.sv
/*
 Tile store
 Nine region memories, halo grid assembly and swapped writeback
 of the write register, which also shifts in serially loaded tiles
*/
`include "fdtd_cfg.svh"

module tile_store (
	input logic clk,
	input logic i_reset,
	input fdtd_pkg::region_addr_t i_raddr,
	input fdtd_pkg::addr_t i_waddr,
	input logic i_we,
	input logic i_init,
	input logic i_init_data,
	input fdtd_pkg::core_tile_t i_result,
	output fdtd_pkg::halo_grid_t o_ex,
	output fdtd_pkg::halo_grid_t o_ey,
	output fdtd_pkg::halo_grid_t o_hzx,
	output fdtd_pkg::halo_grid_t o_hzy,
	output fdtd_pkg::core_tile_t o_core
);
	import fdtd_pkg::*;

	localparam int H = `FDTD_H;
	localparam int W = `FDTD_W;
	localparam int CELL_BITS = $bits(cell_u);
	localparam int TILE_BITS = $bits(core_tile_t);

	cell_u [W-1:0] top_rd, bot_rd, top_wd, bot_wd;     // Horizontal strips
	cell_u [H-1:0] left_rd, right_rd, left_wd, right_wd; // Vertical strips
	cell_u ul_rd, ur_rd, ll_rd, lr_rd;
	cell_u [H+1:0][W+1:0] halo_cell;

	logic [TILE_BITS-1:0] wr_shift; // Write register
	core_tile_t wr_tile;            // Write stage into the memories

	//////////////////////////////////////////////////
	// Write register and writeback fanout

	always_ff @(posedge clk) begin
		if (i_reset)
			wr_shift <= '0;
		else if (i_init)
			wr_shift <= {wr_shift[TILE_BITS-2:0], i_init_data}; // First bit ends at MSB
		else
			wr_shift <= i_result;
	end

	always_ff @(posedge clk) wr_tile <= wr_shift; // Lines up with the registered strobe

	// Edges go to the opposite halo
	always_comb begin
		for (int x = 0; x < W; x++) begin
			top_wd[x] = wr_tile[H-1][x]; // Bottom row
			bot_wd[x] = wr_tile[0][x];
		end
		for (int y = 0; y < H; y++) begin
			left_wd[y] = wr_tile[y][W-1]; // Right column
			right_wd[y] = wr_tile[y][0];
		end
	end

	//////////////////////////////////////////////////
	// Region memories

	tile_ram #(.DATA_BITS(TILE_BITS)) ram_core (
		.clk(clk), .i_we(i_we), .i_waddr(i_waddr), .i_raddr(i_raddr[1][1]),
		.i_wdata(wr_tile), .o_rdata(o_core)
	);
	tile_ram #(.DATA_BITS(W*CELL_BITS)) ram_top (
		.clk(clk), .i_we(i_we), .i_waddr(i_waddr), .i_raddr(i_raddr[0][1]),
		.i_wdata(top_wd), .o_rdata(top_rd)
	);
	tile_ram #(.DATA_BITS(W*CELL_BITS)) ram_bot (
		.clk(clk), .i_we(i_we), .i_waddr(i_waddr), .i_raddr(i_raddr[2][1]),
		.i_wdata(bot_wd), .o_rdata(bot_rd)
	);
	tile_ram #(.DATA_BITS(H*CELL_BITS)) ram_left (
		.clk(clk), .i_we(i_we), .i_waddr(i_waddr), .i_raddr(i_raddr[1][0]),
		.i_wdata(left_wd), .o_rdata(left_rd)
	);
	tile_ram #(.DATA_BITS(H*CELL_BITS)) ram_right (
		.clk(clk), .i_we(i_we), .i_waddr(i_waddr), .i_raddr(i_raddr[1][2]),
		.i_wdata(right_wd), .o_rdata(right_rd)
	);
	tile_ram #(.DATA_BITS(CELL_BITS)) ram_ul ( // UL takes LR
		.clk(clk), .i_we(i_we), .i_waddr(i_waddr), .i_raddr(i_raddr[0][0]),
		.i_wdata(wr_tile[H-1][W-1]), .o_rdata(ul_rd)
	);
	tile_ram #(.DATA_BITS(CELL_BITS)) ram_ur ( // UR takes LL
		.clk(clk), .i_we(i_we), .i_waddr(i_waddr), .i_raddr(i_raddr[0][2]),
		.i_wdata(wr_tile[H-1][0]), .o_rdata(ur_rd)
	);
	tile_ram #(.DATA_BITS(CELL_BITS)) ram_ll ( // LL takes UR
		.clk(clk), .i_we(i_we), .i_waddr(i_waddr), .i_raddr(i_raddr[2][0]),
		.i_wdata(wr_tile[0][W-1]), .o_rdata(ll_rd)
	);
	tile_ram #(.DATA_BITS(CELL_BITS)) ram_lr ( // LR takes UL
		.clk(clk), .i_we(i_we), .i_waddr(i_waddr), .i_raddr(i_raddr[2][2]),
		.i_wdata(wr_tile[0][0]), .o_rdata(lr_rd)
	);

	//////////////////////////////////////////////////
	// Halo grid assembly

	always_comb begin
		for (int y = 0; y < H; y++) begin
			for (int x = 0; x < W; x++) halo_cell[y+1][x+1] = o_core[y][x];
			halo_cell[y+1][0] = left_rd[y];
			halo_cell[y+1][W+1] = right_rd[y];
		end
		for (int x = 0; x < W; x++) begin
			halo_cell[0][x+1] = top_rd[x];
			halo_cell[H+1][x+1] = bot_rd[x];
		end
		halo_cell[0][0] = ul_rd;
		halo_cell[0][W+1] = ur_rd;
		halo_cell[H+1][0] = ll_rd;
		halo_cell[H+1][W+1] = lr_rd;
	end

	// Split cells into field grids
	always_comb begin
		for (int y = 0; y < H+2; y++) begin
			for (int x = 0; x < W+2; x++) begin
				o_ex[y][x] = halo_cell[y][x].f.ex;
				o_ey[y][x] = halo_cell[y][x].f.ey;
				o_hzx[y][x] = halo_cell[y][x].f.hzx;
				o_hzy[y][x] = halo_cell[y][x].f.hzy;
			end
		end
	end
endmodule

//--- src/fdtd_e_update.sv
/*
 FDTD electric field update, stages 1 to 5
 New ex and ey over the halo grid, hzx and hzy delayed alongside
*/
`include "fdtd_cfg.svh"

module fdtd_e_update (
	input logic clk,
	input fdtd_pkg::halo_grid_t i_ex,
	input fdtd_pkg::halo_grid_t i_ey,
	input fdtd_pkg::halo_grid_t i_hzx,
	input fdtd_pkg::halo_grid_t i_hzy,
	input fdtd_pkg::coef_vec_t i_coeff,
	output fdtd_pkg::halo_grid_t o_ex,
	output fdtd_pkg::halo_grid_t o_ey,
	output fdtd_pkg::halo_grid_t o_hzx,
	output fdtd_pkg::halo_grid_t o_hzy
);
	import fdtd_pkg::*;

	localparam int GH = `FDTD_H + 2;
	localparam int GW = `FDTD_W + 2;
	localparam int HZ_DLY = 5;

	halo_grid_t ex1, ey1, hz1;
	halo_grid_t ex2, ey2, dhzx2, dhzy2;
	halo_grid_t p_ex4, p_ey4, p_dhzx4, p_dhzy4; // Scaled products
	halo_grid_t ex5, ey5;
	halo_grid_t hzx_d [HZ_DLY];
	halo_grid_t hzy_d [HZ_DLY];

	//////////////////////////////////////////////////
	// Stage 1 and 2, hz and its backward differences

	always_ff @(posedge clk) begin
		ex1 <= i_ex;
		ey1 <= i_ey;
		for (int y = 0; y < GH; y++) begin
			for (int x = 0; x < GW; x++) hz1[y][x] <= i_hzx[y][x] + i_hzy[y][x];
		end
	end

	always_ff @(posedge clk) begin
		ex2 <= ex1;
		ey2 <= ey1;
		for (int y = 0; y < GH; y++) begin
			dhzx2[y][0] <= '0; // No left neighbour
			for (int x = 1; x < GW; x++) dhzx2[y][x] <= hz1[y][x] - hz1[y][x-1];
		end
		for (int x = 0; x < GW; x++) begin
			dhzy2[0][x] <= '0; // No upper neighbour
			for (int y = 1; y < GH; y++) dhzy2[y][x] <= hz1[y][x] - hz1[y-1][x];
		end
	end

	// Stages 3 and 4
	for (genvar gy = 0; gy < GH; gy++) begin : g_row
		for (genvar gx = 0; gx < GW; gx++) begin : g_col
			coef_mult m_ex (.clk(clk), .i_a(ex2[gy][gx]), .i_c(i_coeff[0]),
				.o_p(p_ex4[gy][gx]));
			coef_mult m_dhzy (.clk(clk), .i_a(dhzy2[gy][gx]), .i_c(i_coeff[1]),
				.o_p(p_dhzy4[gy][gx]));
			coef_mult m_ey (.clk(clk), .i_a(ey2[gy][gx]), .i_c(i_coeff[2]),
				.o_p(p_ey4[gy][gx]));
			coef_mult m_dhzx (.clk(clk), .i_a(dhzx2[gy][gx]), .i_c(i_coeff[3]),
				.o_p(p_dhzx4[gy][gx]));
		end
	end

	// Stage 5, new ex and ey
	always_ff @(posedge clk) begin
		for (int y = 0; y < GH; y++) begin
			for (int x = 0; x < GW; x++) begin
				ex5[y][x] <= p_ex4[y][x] + p_dhzy4[y][x];
				ey5[y][x] <= p_ey4[y][x] + p_dhzx4[y][x];
			end
		end
	end

	// H fields ride along to stage 5
	always_ff @(posedge clk) begin
		hzx_d[0] <= i_hzx;
		hzy_d[0] <= i_hzy;
		for (int k = 1; k < HZ_DLY; k++) begin
			hzx_d[k] <= hzx_d[k-1];
			hzy_d[k] <= hzy_d[k-1];
		end
	end

	assign o_ex = ex5;
	assign o_ey = ey5;
	assign o_hzx = hzx_d[HZ_DLY-1];
	assign o_hzy = hzy_d[HZ_DLY-1];
endmodule

//--- src/fdtd_h_update.sv
/*
 FDTD magnetic field update, stages 6 to 9
 New hzx and hzy for the core cells, packed with the new ex and ey
*/
`include "fdtd_cfg.svh"

module fdtd_h_update (
	input logic clk,
	input fdtd_pkg::halo_grid_t i_ex,
	input fdtd_pkg::halo_grid_t i_ey,
	input fdtd_pkg::halo_grid_t i_hzx,
	input fdtd_pkg::halo_grid_t i_hzy,
	input fdtd_pkg::coef_vec_t i_coeff,
	output fdtd_pkg::core_tile_t o_result
);
	import fdtd_pkg::*;

	localparam int H = `FDTD_H;
	localparam int W = `FDTD_W;
	localparam int E_DLY = 4; // Stages 6 to 9

	field_t [H-1:0][W-1:0] dexy6, deyx6, hzx6, hzy6;
	field_t [H-1:0][W-1:0] p_hzx8, p_deyx8, p_hzy8, p_dexy8;
	field_t [H-1:0][W-1:0] hzx9, hzy9;
	field_t [H-1:0][W-1:0] ex_d [E_DLY];
	field_t [H-1:0][W-1:0] ey_d [E_DLY];

	//////////////////////////////////////////////////
	// Stage 6, forward differences on the core

	always_ff @(posedge clk) begin
		for (int y = 0; y < H; y++) begin
			for (int x = 0; x < W; x++) begin
				dexy6[y][x] <= i_ex[y+2][x+1] - i_ex[y+1][x+1]; // Cell below
				deyx6[y][x] <= i_ey[y+1][x+2] - i_ey[y+1][x+1]; // Cell to the right
				hzx6[y][x] <= i_hzx[y+1][x+1];
				hzy6[y][x] <= i_hzy[y+1][x+1];
				ex_d[0][y][x] <= i_ex[y+1][x+1];
				ey_d[0][y][x] <= i_ey[y+1][x+1];
			end
		end
		for (int k = 1; k < E_DLY; k++) begin
			ex_d[k] <= ex_d[k-1];
			ey_d[k] <= ey_d[k-1];
		end
	end

	// Stages 7 and 8
	for (genvar gy = 0; gy < H; gy++) begin : g_row
		for (genvar gx = 0; gx < W; gx++) begin : g_col
			coef_mult m_hzx (.clk(clk), .i_a(hzx6[gy][gx]), .i_c(i_coeff[4]),
				.o_p(p_hzx8[gy][gx]));
			coef_mult m_deyx (.clk(clk), .i_a(deyx6[gy][gx]), .i_c(i_coeff[5]),
				.o_p(p_deyx8[gy][gx]));
			coef_mult m_hzy (.clk(clk), .i_a(hzy6[gy][gx]), .i_c(i_coeff[6]),
				.o_p(p_hzy8[gy][gx]));
			coef_mult m_dexy (.clk(clk), .i_a(dexy6[gy][gx]), .i_c(i_coeff[7]),
				.o_p(p_dexy8[gy][gx]));
		end
	end

	// Stage 9, new hzx and hzy
	always_ff @(posedge clk) begin
		for (int y = 0; y < H; y++) begin
			for (int x = 0; x < W; x++) begin
				hzx9[y][x] <= p_hzx8[y][x] + p_deyx8[y][x];
				hzy9[y][x] <= p_hzy8[y][x] + p_dexy8[y][x];
			end
		end
	end

	// Pack result cells
	always_comb begin
		for (int y = 0; y < H; y++) begin
			for (int x = 0; x < W; x++) begin
				o_result[y][x].f.ex = ex_d[E_DLY-1][y][x];
				o_result[y][x].f.ey = ey_d[E_DLY-1][y][x];
				o_result[y][x].f.hzx = hzx9[y][x];
				o_result[y][x].f.hzy = hzy9[y][x];
			end
		end
	end
endmodule

//--- src/fdtd_top.sv
/*
 FDTD tile engine top
 Input registers, tile store, E and H update pipeline, snapshot port
*/
`include "fdtd_cfg.svh"

module fdtd_top (
	input logic clk,
	input logic i_reset,
	input fdtd_pkg::region_addr_t i_raddr,
	input fdtd_pkg::addr_t i_waddr,
	input logic i_we,
	input fdtd_pkg::coef_vec_t i_coeff,
	input logic i_ld,
	input logic i_init,
	input logic i_init_data,
	output fdtd_pkg::core_tile_t o_dout
);
	import fdtd_pkg::*;

	localparam int LD = `FDTD_LD_LAT;

	region_addr_t raddr_q; // Heavy fanout
	addr_t waddr_q;
	coef_vec_t coeff_q;
	logic we_q;
	logic init_q;
	logic init_data_q;
	logic [LD-1:0] ld_del; // Stage 0 is the input register

	halo_grid_t st_ex, st_ey, st_hzx, st_hzy;
	halo_grid_t e_ex, e_ey, e_hzx, e_hzy;
	core_tile_t result;
	core_tile_t core_rd;

	always_ff @(posedge clk) begin
		raddr_q <= i_raddr;
		waddr_q <= i_waddr;
		coeff_q <= i_coeff;
		init_data_q <= i_init_data;
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			we_q <= 1'b0;
			init_q <= 1'b0;
			ld_del <= '0;
			o_dout <= '0;
		end else begin
			we_q <= i_we;
			init_q <= i_init;
			ld_del <= {ld_del[LD-2:0], i_ld}; // Lines up with core read data
			if (ld_del[LD-1]) o_dout <= core_rd; // Snapshot, otherwise hold
		end
	end

	tile_store store_i (
		.clk(clk), .i_reset(i_reset), .i_raddr(raddr_q), .i_waddr(waddr_q),
		.i_we(we_q), .i_init(init_q), .i_init_data(init_data_q), .i_result(result),
		.o_ex(st_ex), .o_ey(st_ey), .o_hzx(st_hzx), .o_hzy(st_hzy), .o_core(core_rd)
	);

	fdtd_e_update e_update_i (
		.clk(clk), .i_ex(st_ex), .i_ey(st_ey), .i_hzx(st_hzx), .i_hzy(st_hzy),
		.i_coeff(coeff_q), .o_ex(e_ex), .o_ey(e_ey), .o_hzx(e_hzx), .o_hzy(e_hzy)
	);

	fdtd_h_update h_update_i (
		.clk(clk), .i_ex(e_ex), .i_ey(e_ey), .i_hzx(e_hzx), .i_hzy(e_hzy),
		.i_coeff(coeff_q), .o_result(result)
	);
endmodule

//--- bench/fdtd_model.svh
/*
 FDTD reference model for the testbench
 Region arrays, halo assembly, step rule, swapped writeback, xorshift
*/
`ifndef FDTD_MODEL_SVH
`define FDTD_MODEL_SVH

localparam int F = `FDTD_FBITS;
localparam int MW = `FDTD_W;
localparam int MH = `FDTD_H;
localparam int CB = 4 * F;             // Bits per cell
localparam int TILE_BITS = MW * MH * CB;
localparam int FRAC = `FDTD_COEF_FRAC;
localparam int DEPTH = 1 << `FDTD_ABITS;

// Region contents by address
logic [TILE_BITS-1:0] m_core [DEPTH];
logic [CB-1:0] m_top [DEPTH][MW];
logic [CB-1:0] m_bot [DEPTH][MW];
logic [CB-1:0] m_left [DEPTH][MH];
logic [CB-1:0] m_right [DEPTH][MH];
logic [CB-1:0] m_ul [DEPTH];
logic [CB-1:0] m_ur [DEPTH];
logic [CB-1:0] m_ll [DEPTH];
logic [CB-1:0] m_lr [DEPTH];

logic [31:0] rng_state;

function automatic logic [31:0] xorshift32();
	logic [31:0] x;
	x = rng_state;
	x ^= x << 13;
	x ^= x >> 17;
	x ^= x << 5;
	rng_state = x;
	return x;
endfunction

// Cell (y, x) sits in slot y*W+x with slot 0 at the LSB
function automatic logic [CB-1:0] tile_cell(input logic [TILE_BITS-1:0] t, input int y,
		input int x);
	return t[(y * MW + x) * CB +: CB];
endfunction

// Full product shifted right arithmetically and cut to field width
function automatic field_t scale(input field_t a, input field_t c);
	logic signed [2*F-1:0] p;
	logic signed [2*F-1:0] q;
	p = a * c;
	q = p >>> FRAC;
	return q[F-1:0];
endfunction

task automatic write_regions(input addr_t a, input logic [TILE_BITS-1:0] t);
	m_core[a] = t;
	for (int x = 0; x < MW; x++) begin
		m_top[a][x] = tile_cell(t, MH - 1, x); // Bottom row into top strip
		m_bot[a][x] = tile_cell(t, 0, x);
	end
	for (int y = 0; y < MH; y++) begin
		m_left[a][y] = tile_cell(t, y, MW - 1);
		m_right[a][y] = tile_cell(t, y, 0);
	end
	m_ul[a] = tile_cell(t, MH - 1, MW - 1);
	m_ur[a] = tile_cell(t, MH - 1, 0);
	m_ll[a] = tile_cell(t, 0, MW - 1);
	m_lr[a] = tile_cell(t, 0, 0);
endtask

function automatic logic [TILE_BITS-1:0] step_tile(input region_addr_t ra, input coef_vec_t c);
	logic [CB-1:0] g [MH+2][MW+2];
	field_t ex [MH+2][MW+2];
	field_t ey [MH+2][MW+2];
	field_t hzx [MH+2][MW+2];
	field_t hzy [MH+2][MW+2];
	field_t hz [MH+2][MW+2];
	field_t exn [MH+2][MW+2];
	field_t eyn [MH+2][MW+2];
	field_t d;
	field_t nhzx;
	field_t nhzy;
	logic [TILE_BITS-1:0] r;

	// Halo assembly
	for (int y = 0; y < MH; y++) begin
		for (int x = 0; x < MW; x++) g[y+1][x+1] = tile_cell(m_core[ra[1][1]], y, x);
		g[y+1][0] = m_left[ra[1][0]][y];
		g[y+1][MW+1] = m_right[ra[1][2]][y];
	end
	for (int x = 0; x < MW; x++) begin
		g[0][x+1] = m_top[ra[0][1]][x];
		g[MH+1][x+1] = m_bot[ra[2][1]][x];
	end
	g[0][0] = m_ul[ra[0][0]];
	g[0][MW+1] = m_ur[ra[0][2]];
	g[MH+1][0] = m_ll[ra[2][0]];
	g[MH+1][MW+1] = m_lr[ra[2][2]];

	for (int y = 0; y < MH + 2; y++) begin
		for (int x = 0; x < MW + 2; x++) begin
			ex[y][x] = g[y][x][3*F +: F];
			ey[y][x] = g[y][x][2*F +: F];
			hzx[y][x] = g[y][x][F +: F];
			hzy[y][x] = g[y][x][0 +: F];
			hz[y][x] = hzx[y][x] + hzy[y][x];
		end
	end

	// E update wherever a backward difference exists
	for (int y = 1; y < MH + 2; y++) begin
		for (int x = 1; x < MW + 2; x++) begin
			d = hz[y][x] - hz[y-1][x];
			exn[y][x] = scale(ex[y][x], c[0]) + scale(d, c[1]);
			d = hz[y][x] - hz[y][x-1];
			eyn[y][x] = scale(ey[y][x], c[2]) + scale(d, c[3]);
		end
	end

	// H update on the core only
	for (int y = 1; y <= MH; y++) begin
		for (int x = 1; x <= MW; x++) begin
			d = eyn[y][x+1] - eyn[y][x];
			nhzx = scale(hzx[y][x], c[4]) + scale(d, c[5]);
			d = exn[y+1][x] - exn[y][x];
			nhzy = scale(hzy[y][x], c[6]) + scale(d, c[7]);
			r[((y - 1) * MW + (x - 1)) * CB +: CB] = {exn[y][x], eyn[y][x], nhzx, nhzy};
		end
	end
	return r;
endfunction

`endif

//--- bench/fdtd_tb.sv
/*
 FDTD tile engine testbench
 Serial loads, snapshots and chained step generations against a model
*/
`include "fdtd_cfg.svh"

module fdtd_tb;
	import fdtd_pkg::*;

	`include "fdtd_model.svh"

	localparam int PERIOD = 20;
	localparam int TILES = 8;     // Tiles loaded, also steps per generation
	localparam int GENS = 4;
	localparam int STEPS = TILES * GENS;
	localparam int STEP_LAT = `FDTD_STEP_LAT;
	localparam int LD_LEN = `FDTD_LD_LAT + 1; // Strobe edge plus delay edges
	localparam int WATCHDOG = 2 * (TILES * (TILE_BITS + 20) + STEPS * 20);

	logic clk;
	logic i_reset;
	region_addr_t i_raddr;
	addr_t i_waddr;
	logic i_we;
	coef_vec_t i_coeff;
	logic i_ld;
	logic i_init;
	logic i_init_data;
	core_tile_t o_dout;

	int errors = 0;
	int checks = 0;
	logic monitor_on = 1'b0;
	logic [TILE_BITS-1:0] exp_dout = '0;
	logic ld_line [LD_LEN] = '{default: 1'b0};
	logic [TILE_BITS-1:0] ld_tile [LD_LEN];

	fdtd_top fdtd_top_i (
		.clk(clk), .i_reset(i_reset), .i_raddr(i_raddr), .i_waddr(i_waddr), .i_we(i_we),
		.i_coeff(i_coeff), .i_ld(i_ld), .i_init(i_init), .i_init_data(i_init_data),
		.o_dout(o_dout)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Snapshot tracking, o_dout checked every cycle

	always @(negedge clk) begin
		if (monitor_on) begin
			if (ld_line[LD_LEN-1]) exp_dout = ld_tile[LD_LEN-1]; // Strobe arrives
			for (int k = LD_LEN - 1; k > 0; k--) begin
				ld_line[k] = ld_line[k-1];
				ld_tile[k] = ld_tile[k-1];
			end
			ld_line[0] = i_ld;
			ld_tile[0] = m_core[i_raddr[1][1]];
			checks++;
			if (o_dout !== exp_dout) begin
				errors++;
				$display("Fail %0t: o_dout %h, expected %h", $time, o_dout, exp_dout);
			end
		end
	end

	//////////////////////////////////////////////////
	// Stimulus tasks, entered right after a rising edge

	task automatic send_snapshot(input addr_t a);
		region_addr_t ra;
		ra = '0;
		ra[1][1] = a;
		i_raddr <= ra;
		i_ld <= 1'b1;
		@(posedge clk);
		i_ld <= 1'b0;
	endtask

	task automatic load_tile(input addr_t a);
		logic [TILE_BITS-1:0] t;
		t = '0;
		for (int k = 0; k < (TILE_BITS + 31) / 32; k++) t = {t[TILE_BITS-33:0], xorshift32()};
		for (int k = TILE_BITS - 1; k >= 0; k--) begin // MSB first
			@(posedge clk);
			i_init <= 1'b1;
			i_init_data <= t[k];
		end
		@(posedge clk);
		i_init <= 1'b0;
		@(posedge clk);
		i_we <= 1'b1;
		i_waddr <= a;
		write_regions(a, t);
		@(posedge clk);
		i_we <= 1'b0;
		@(posedge clk);
		send_snapshot(a);
	endtask

	// One generation reads tiles at src, writes results at dst
	task automatic run_generation(input int src, input int dst, input logic unit_gain);
		region_addr_t ra [TILES];
		coef_vec_t c;
		logic [31:0] r;
		int ctr;
		for (int k = 0; k < 8; k++) begin
			r = xorshift32();
			if (unit_gain && (k % 2 == 0))
				c[k] = field_t'(1 << FRAC);
			else
				c[k] = r[F-1:0];
		end
		for (int s = 0; s < TILES; s++) begin
			ctr = int'(xorshift32() % TILES);
			for (int row = 0; row < 3; row++) begin
				for (int col = 0; col < 3; col++) begin
					if (row == 1 && col == 1)
						ra[s][row][col] = addr_t'(src + ctr);
					else
						ra[s][row][col] = addr_t'(src +
							(ctr + 1 + int'(xorshift32() % (TILES - 1))) % TILES);
				end
			end
		end
		i_coeff <= c; // Only changed with nothing in flight
		repeat (2) @(posedge clk);
		for (int cyc = 0; cyc < TILES + STEP_LAT; cyc++) begin
			if (cyc < TILES) begin
				i_raddr <= ra[cyc];
				write_regions(addr_t'(dst + cyc), step_tile(ra[cyc], c));
			end else begin
				i_raddr <= '0;
			end
			if (cyc >= STEP_LAT) begin
				i_we <= 1'b1;
				i_waddr <= addr_t'(dst + cyc - STEP_LAT);
			end
			@(posedge clk);
		end
		i_we <= 1'b0;
		repeat (2) @(posedge clk);
		for (int s = 0; s < TILES; s++) send_snapshot(addr_t'(dst + s));
	endtask

	//////////////////////////////////////////////////
	// Main sequence

	initial begin
		rng_state = 32'h7c2a_fe50;
		i_reset = 1'b1;
		i_raddr = '0;
		i_waddr = '0;
		i_we = 1'b0;
		i_coeff = '0;
		i_ld = 1'b0;
		i_init = 1'b0;
		i_init_data = 1'b0;
		repeat (2) @(posedge clk);
		i_reset <= 1'b0;
		monitor_on = 1'b1;
		repeat (4) @(posedge clk); // o_dout stays zero here
		for (int k = 0; k < TILES; k++) load_tile(addr_t'(k));
		run_generation(0, TILES, 1'b1);
		for (int g = 1; g < GENS; g++) run_generation(g * TILES, (g + 1) * TILES, 1'b0);
		repeat (LD_LEN + 4) @(posedge clk);
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		#(WATCHDOG * PERIOD);
		$display("Watchdog timeout, the run did not finish within %0d cycles", WATCHDOG);
		$display("TESTBENCH FAILED");
		$finish;
	end
endmodule

//--- vlog.f
+incdir+include
+incdir+bench
src/fdtd_pkg.sv
src/tile_ram.sv
src/coef_mult.sv
src/tile_store.sv
src/fdtd_e_update.sv
src/fdtd_h_update.sv
src/fdtd_top.sv
bench/fdtd_tb.sv

//--- run.sh
#!/bin/sh
# Build fdtd_tb with Verilator, run it, judge the simulation log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module fdtd_tb -f vlog.f -o fdtd_sim > build.log 2>&1 \
	&& ./obj_dir/fdtd_sim > sim.log 2>&1 \
	|| { echo "Build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "TESTBENCH FAILED" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
echo "Simulation passed"
exit 0
